/* common/bus_pkg.sv */
package bus_pkg;

    // ********************
    // Widths and types
    // ********************
    localparam int BUS_ADDR_W = 16;                  // Host address width.
    localparam int BUS_DATA_W = 8;                   // Data bus width.
    localparam int REG_ADDR_W = 4;                   // Register index inside a window.

    typedef logic [BUS_ADDR_W-1:0] bus_addr_t;
    typedef logic [BUS_DATA_W-1:0] bus_data_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // ********************
    // Address map
    // ********************
    localparam bus_addr_t ADD_OFFSET    = 16'h4000;  // Host to bus address offset.

    localparam bus_addr_t GPIO_BASEADDR = 16'h0000;
    localparam bus_addr_t GPIO_HIGHADDR = 16'h000F;

    localparam bus_addr_t CNT_BASEADDR  = 16'h0010;
    localparam bus_addr_t CNT_HIGHADDR  = 16'h001F;

    // ********************
    // Register indices
    // ********************
    localparam reg_addr_t GPIO_REG_IN   = 4'd0;      // Synchronized pin levels.
    localparam reg_addr_t GPIO_REG_OUT  = 4'd1;      // Output data.
    localparam reg_addr_t GPIO_REG_DIR  = 4'd2;      // Direction, 1 is output.

    localparam reg_addr_t CNT_REG_LO    = 4'd0;      // Count low byte, loads snapshot.
    localparam reg_addr_t CNT_REG_HI    = 4'd1;      // Snapshot high byte.
    localparam reg_addr_t CNT_REG_CTRL  = 4'd2;      // Bit 0 enable, bit 1 clear.

    // Control register bit positions.
    localparam int CNT_CTRL_EN_BIT  = 0;
    localparam int CNT_CTRL_CLR_BIT = 1;

endpackage

/* common/reg_if.sv */
`timescale 1ns/10ps

// Single-cycle register access between the bus controller and one peripheral.
interface reg_if;
    import bus_pkg::*;

    reg_addr_t addr;                                 // Register index in the window.
    bus_data_t wdata;                                // Write data from the host.
    logic      wr;                                   // One-cycle write strobe.
    logic      rd;                                   // One-cycle read strobe.
    bus_data_t rdata;                                // Combinational read data.

    modport ctrl (
        output addr,
        output wdata,
        output wr,
        output rd,
        input  rdata
    );

    modport periph (
        input  addr,
        input  wdata,
        input  wr,
        input  rd,
        output rdata
    );

endinterface

/* bus_ctrl/bus_ctrl.sv */
`timescale 1ns/10ps

module bus_ctrl #(
    parameter bus_pkg::bus_addr_t GPIO_BASE = bus_pkg::GPIO_BASEADDR,
    parameter bus_pkg::bus_addr_t GPIO_HIGH = bus_pkg::GPIO_HIGHADDR,
    parameter bus_pkg::bus_addr_t CNT_BASE  = bus_pkg::CNT_BASEADDR,
    parameter bus_pkg::bus_addr_t CNT_HIGH  = bus_pkg::CNT_HIGHADDR
) (
    input  wire                     bus_clk,
    input  wire                     rst_n,
    input  wire bus_pkg::bus_addr_t add,
    input  wire                     rd_b,
    input  wire                     wr_b,
    inout  wire bus_pkg::bus_data_t bus_data,
    reg_if.ctrl                     gpio_bus,
    reg_if.ctrl                     cnt_bus
);
    import bus_pkg::*;

    // Strobe vector layout.
    localparam int WR_IDX = 0;
    localparam int RD_IDX = 1;

    bus_addr_t  bus_addr;                            // Host address minus offset.
    logic       gpio_sel;
    logic       cnt_sel;

    logic [1:0] strb_s1;                             // First sync stage, active low.
    logic [1:0] strb_s2;                             // Second sync stage.
    logic [1:0] strb_s3;                             // Delayed copy for the edge detect.
    logic [1:0] strb_pulse;                          // One-cycle access pulses.
    logic       rd_pulse;
    logic       wr_pulse;

    bus_data_t  read_data;                           // Byte latched on the read pulse.
    logic       bus_data_oe;                         // Data bus driver enable.

    // ********************
    // Address decode
    // ********************
    assign bus_addr = add - ADD_OFFSET;

    assign gpio_sel = (bus_addr >= GPIO_BASE) && (bus_addr <= GPIO_HIGH);
    assign cnt_sel  = (bus_addr >= CNT_BASE) && (bus_addr <= CNT_HIGH);

    // ********************
    // Strobe synchronizer
    // ********************
    // Both strobes share one chain, so rd and wr see identical latency.
    always_ff @(posedge bus_clk) begin
        if (!rst_n) begin
            strb_s1    <= 2'b11;                     // Strobes idle high.
            strb_s2    <= 2'b11;
            strb_s3    <= 2'b11;
            strb_pulse <= 2'b00;
        end else begin
            strb_s1    <= {rd_b, wr_b};
            strb_s2    <= strb_s1;
            strb_s3    <= strb_s2;
            strb_pulse <= strb_s3 & ~strb_s2;        // Falling edge of the synced strobe.
        end
    end

    assign rd_pulse = strb_pulse[RD_IDX];
    assign wr_pulse = strb_pulse[WR_IDX];

    // ********************
    // Peripheral channels
    // ********************
    assign gpio_bus.addr  = bus_addr[REG_ADDR_W-1:0];
    assign gpio_bus.wdata = bus_data;                // Host holds data while wr_b is low.
    assign gpio_bus.wr    = wr_pulse & gpio_sel;
    assign gpio_bus.rd    = rd_pulse & gpio_sel;

    assign cnt_bus.addr   = bus_addr[REG_ADDR_W-1:0];
    assign cnt_bus.wdata  = bus_data;
    assign cnt_bus.wr     = wr_pulse & cnt_sel;
    assign cnt_bus.rd     = rd_pulse & cnt_sel;

    // ********************
    // Read path
    // ********************
    always_ff @(posedge bus_clk) begin
        if (rd_pulse) begin
            if (gpio_sel)
                read_data <= gpio_bus.rdata;
            else if (cnt_sel)
                read_data <= cnt_bus.rdata;
            else
                read_data <= '0;                     // Unmapped address.
        end
    end

    // Drive from the cycle after the pulse until the synced rd_b is high again.
    always_ff @(posedge bus_clk) begin
        if (!rst_n) begin
            bus_data_oe <= 1'b0;
        end else if (rd_pulse) begin
            bus_data_oe <= 1'b1;
        end else if (strb_s2[RD_IDX]) begin
            bus_data_oe <= 1'b0;
        end
    end

    assign bus_data = bus_data_oe ? read_data : 'z;

endmodule

/* gpio/gpio_port.sv */
`timescale 1ns/10ps

module gpio_port (
    input  wire       bus_clk,
    input  wire       rst_n,
    reg_if.periph     regs,
    inout  wire [7:0] io
);
    import bus_pkg::*;

    bus_data_t out_reg;                              // Output data.
    bus_data_t dir_reg;                              // 1 drives the pin.
    bus_data_t in_s1;                                // Pin sampling, first stage.
    bus_data_t in_reg;                               // Synchronized pin levels.

    // ********************
    // Register writes
    // ********************
    always_ff @(posedge bus_clk) begin
        if (!rst_n) begin
            out_reg <= '0;
            dir_reg <= '0;                           // All pins start as inputs.
        end else if (regs.wr) begin
            case (regs.addr)
                GPIO_REG_OUT: out_reg <= regs.wdata;
                GPIO_REG_DIR: dir_reg <= regs.wdata;
                default: ;                           // Read-only or unmapped.
            endcase
        end
    end

    // ********************
    // Pin drive
    // ********************
    for (genvar i = 0; i < 8; i++) begin : g_pin
        assign io[i] = dir_reg[i] ? out_reg[i] : 1'bz;
    end

    // Two-stage sampling, the input register lags the pins by two cycles.
    always_ff @(posedge bus_clk) begin
        in_s1  <= io;
        in_reg <= in_s1;
    end

    // ********************
    // Read data
    // ********************
    always_comb begin
        case (regs.addr)
            GPIO_REG_IN:  regs.rdata = in_reg;
            GPIO_REG_OUT: regs.rdata = out_reg;
            GPIO_REG_DIR: regs.rdata = dir_reg;
            default:      regs.rdata = '0;
        endcase
    end

endmodule

/* event_counter/event_counter.sv */
`timescale 1ns/10ps

module event_counter #(
    parameter int CNT_WIDTH = 16                     // Valid from 9 to 16.
) (
    input  wire   bus_clk,
    input  wire   rst_n,
    reg_if.periph regs,
    input  wire   event_in
);
    import bus_pkg::*;

    logic                 ev_s1;                     // Event synchronizer.
    logic                 ev_s2;
    logic                 ev_s3;                     // Previous level for edge detect.
    logic                 ev_rise;

    logic                 cnt_en;
    logic                 ctrl_wr;
    logic                 clr_req;
    logic                 snap_load;
    logic [CNT_WIDTH-1:0] count;
    bus_data_t            snap;                      // High byte captured on a low read.

    // ********************
    // Event edge detect
    // ********************
    always_ff @(posedge bus_clk) begin
        if (!rst_n) begin
            ev_s1 <= 1'b0;
            ev_s2 <= 1'b0;
            ev_s3 <= 1'b0;
        end else begin
            ev_s1 <= event_in;
            ev_s2 <= ev_s1;
            ev_s3 <= ev_s2;
        end
    end

    assign ev_rise = ev_s2 & ~ev_s3;

    // ********************
    // Control register
    // ********************
    assign ctrl_wr   = regs.wr && (regs.addr == CNT_REG_CTRL);
    assign clr_req   = ctrl_wr && regs.wdata[CNT_CTRL_CLR_BIT];  // Self-clearing.
    assign snap_load = regs.rd && (regs.addr == CNT_REG_LO);

    always_ff @(posedge bus_clk) begin
        if (!rst_n) begin
            cnt_en <= 1'b0;
        end else if (ctrl_wr) begin
            cnt_en <= regs.wdata[CNT_CTRL_EN_BIT];
        end
    end

    // ********************
    // Counter and snapshot
    // ********************
    // Clear wins over a coincident event.
    always_ff @(posedge bus_clk) begin
        if (!rst_n) begin
            count <= '0;
        end else if (clr_req) begin
            count <= '0;
        end else if (cnt_en && ev_rise) begin
            count <= count + 1'b1;                   // Wraps at the full width.
        end
    end

    // The low read and the snapshot see the same count value.
    always_ff @(posedge bus_clk) begin
        if (!rst_n) begin
            snap <= '0;
        end else if (snap_load) begin
            snap <= bus_data_t'(count[CNT_WIDTH-1:BUS_DATA_W]);
        end
    end

    // ********************
    // Read data
    // ********************
    always_comb begin
        case (regs.addr)
            CNT_REG_LO:   regs.rdata = count[BUS_DATA_W-1:0];
            CNT_REG_HI:   regs.rdata = snap;
            CNT_REG_CTRL: regs.rdata = bus_data_t'(cnt_en);  // Clear bit reads 0.
            default:      regs.rdata = '0;
        endcase
    end

endmodule

/* src/bus_top.sv */
`timescale 1ns/10ps

module bus_top #(
    parameter int CNT_WIDTH = 16                     // Event counter width, 9 to 16.
) (
    input  wire                     bus_clk,
    input  wire                     rst_n,

    // Host bus.
    input  wire bus_pkg::bus_addr_t add,
    input  wire                     rd_b,
    input  wire                     wr_b,
    inout  wire bus_pkg::bus_data_t bus_data,

    // Board pins.
    inout  wire [7:0]               io,
    input  wire                     event_in
);
    import bus_pkg::*;

    // One register channel per peripheral.
    reg_if gpio_bus ();
    reg_if cnt_bus ();

    // ********************
    // Bus controller
    // ********************
    bus_ctrl #(
        .GPIO_BASE (GPIO_BASEADDR),
        .GPIO_HIGH (GPIO_HIGHADDR),
        .CNT_BASE  (CNT_BASEADDR),
        .CNT_HIGH  (CNT_HIGHADDR)
    ) i_bus_ctrl (
        .bus_clk   (bus_clk),
        .rst_n     (rst_n),
        .add       (add),
        .rd_b      (rd_b),
        .wr_b      (wr_b),
        .bus_data  (bus_data),
        .gpio_bus  (gpio_bus.ctrl),
        .cnt_bus   (cnt_bus.ctrl)
    );

    // ********************
    // Peripherals
    // ********************
    gpio_port i_gpio_port (
        .bus_clk   (bus_clk),
        .rst_n     (rst_n),
        .regs      (gpio_bus.periph),
        .io        (io)
    );

    event_counter #(
        .CNT_WIDTH (CNT_WIDTH)
    ) i_event_counter (
        .bus_clk   (bus_clk),
        .rst_n     (rst_n),
        .regs      (cnt_bus.periph),
        .event_in  (event_in)
    );

endmodule

/* tests/clk_rst_gen.sv */
`timescale 1ns/10ps

module clk_rst_gen #(
    parameter int PERIOD       = 40,                 // Clock period in ns.
    parameter int RESET_CYCLES = 4,
    parameter int DRIVE_DELAY  = 5                   // Input delay after the rising edge.
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Reset is released just after an edge, like every other input.
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;
    end

endmodule

/* tests/bus_top_chk.sv */
`timescale 1ns/10ps

module bus_top_chk (
    input wire bus_clk,
    input wire rst_n,
    input wire rd_b,
    input wire rd_pulse,
    input wire wr_pulse,
    input wire bus_data_oe
);
    int fail_count = 0;                              // Read by the testbench at the end.

    a_wr_single: assert property (@(posedge bus_clk) disable iff (!rst_n)
        wr_pulse |=> !wr_pulse)
        else begin
            fail_count++;
            $error("wr pulse lasts more than one cycle");
        end

    a_rd_single: assert property (@(posedge bus_clk) disable iff (!rst_n)
        rd_pulse |=> !rd_pulse)
        else begin
            fail_count++;
            $error("rd pulse lasts more than one cycle");
        end

    a_no_overlap: assert property (@(posedge bus_clk) disable iff (!rst_n)
        !(wr_pulse && rd_pulse))
        else begin
            fail_count++;
            $error("rd and wr pulses coincide");
        end

    // Release takes up to 3 cycles after rd_b rises.
    a_oe_read: assert property (@(posedge bus_clk) disable iff (!rst_n)
        bus_data_oe |-> !(rd_b && $past(rd_b, 1) && $past(rd_b, 2) && $past(rd_b, 3)))
        else begin
            fail_count++;
            $error("data bus driven with no read active");
        end

    a_oe_reset: assert property (@(posedge bus_clk) !rst_n |=> !bus_data_oe)
        else begin
            fail_count++;
            $error("data bus driven during reset");
        end

endmodule

bind bus_ctrl bus_top_chk i_bus_top_chk (
    .bus_clk     (bus_clk),
    .rst_n       (rst_n),
    .rd_b        (rd_b),
    .rd_pulse    (rd_pulse),
    .wr_pulse    (wr_pulse),
    .bus_data_oe (bus_data_oe)
);

/* tests/tb_bus_top.sv */
`timescale 1ns/10ps

module tb_bus_top;
    import bus_pkg::*;

    localparam int CLK_PERIOD  = 40;
    localparam int DRIVE_DELAY = 5;
    localparam int LOW_CYCLES  = 7;                  // Strobe low time per access.
    localparam int IDLE_CYCLES = 4;
    localparam int N_GPIO      = 8;
    localparam int N_MIX       = 8;
    localparam int N_ROUNDS    = 2;
    localparam int MAX_EVENTS  = 300;
    localparam int MAX_OFF_EV  = 15;                 // Events sent while disabled.
    localparam int N_UNMAP     = 6;
    localparam int N_ACCESS    = 5 + 4 * N_GPIO + 2 * N_MIX + 5 * N_ROUNDS + 5 + 4 * 13
                                 + 2 * N_UNMAP + 6 + 7;
    localparam int N_EVENTS    = N_ROUNDS * (MAX_EVENTS + MAX_OFF_EV);
    localparam int TIMEOUT_NS  = (N_ACCESS * 12 + N_EVENTS * 8 + 200) * CLK_PERIOD;

    logic        bus_clk;
    logic        rst_n;
    bus_addr_t   add;
    logic        rd_b;
    logic        wr_b;
    wire  [7:0]  bus_data;
    wire  [7:0]  io;
    logic        event_in;

    bus_data_t   wr_data;                            // Host write driver.
    logic        wr_drive;
    bus_data_t   tb_pins;                            // Levels driven onto input pins.

    bus_data_t   exp_out;                            // Register model.
    bus_data_t   exp_dir;
    logic        exp_en;
    logic [15:0] exp_cnt;

    integer      seed;
    int          data_err = 0;
    int          count_err = 0;
    int          other_err = 0;

    string       name_q[$];                          // Results waiting for comparison.
    bus_data_t   got_q[$];
    bus_data_t   exp_q[$];
    logic [15:0] cnt_got_q[$];
    logic [15:0] cnt_exp_q[$];

    clk_rst_gen #(.PERIOD(CLK_PERIOD), .DRIVE_DELAY(DRIVE_DELAY)) i_clk_rst_gen (
        .clk   (bus_clk),
        .rst_n (rst_n)
    );

    bus_top i_bus_top (
        .bus_clk  (bus_clk),
        .rst_n    (rst_n),
        .add      (add),
        .rd_b     (rd_b),
        .wr_b     (wr_b),
        .bus_data (bus_data),
        .io       (io),
        .event_in (event_in)
    );

    assign bus_data = wr_drive ? wr_data : 'z;

    for (genvar i = 0; i < 8; i++) begin : g_pin_drv
        assign io[i] = exp_dir[i] ? 1'bz : tb_pins[i];   // Off where the DUT drives.
    end

    // ********************
    // Reference and helpers
    // ********************
    function automatic bus_data_t gpio_in_ref(bus_data_t out_v, bus_data_t dir_v,
                                              bus_data_t pins_v);
        return (out_v & dir_v) | (pins_v & ~dir_v);
    endfunction

    function automatic bus_addr_t gpio_addr(reg_addr_t idx);
        return ADD_OFFSET + GPIO_BASEADDR + bus_addr_t'(idx);
    endfunction

    function automatic bus_addr_t cnt_addr(reg_addr_t idx);
        return ADD_OFFSET + CNT_BASEADDR + bus_addr_t'(idx);
    endfunction

    task automatic wait_cycles(int n);
        repeat (n) @(posedge bus_clk);
        #DRIVE_DELAY;
    endtask

    task automatic bus_write(bus_addr_t a, bus_data_t d);
        add      = a;
        wr_data  = d;
        wr_drive = 1'b1;
        wr_b     = 1'b0;
        wait_cycles(LOW_CYCLES);
        wr_b     = 1'b1;
        wr_drive = 1'b0;
        wait_cycles(IDLE_CYCLES);
    endtask

    task automatic bus_read(bus_addr_t a, output bus_data_t d);
        add  = a;
        rd_b = 1'b0;
        wait_cycles(LOW_CYCLES);
        d    = bus_data;                             // Last moment before rd_b rises.
        rd_b = 1'b1;
        wait_cycles(IDLE_CYCLES);
    endtask

    task automatic post_data(string name, bus_data_t got, bus_data_t exp);
        name_q.push_back(name);
        got_q.push_back(got);
        exp_q.push_back(exp);
    endtask

    task automatic read_expect(string name, bus_addr_t a, bus_data_t exp);
        bus_data_t d;
        bus_read(a, d);
        post_data(name, d, exp);
    endtask

    // Low byte first, so the high byte comes from the snapshot.
    task automatic read_count_pair();
        bus_data_t lo;
        bus_data_t hi;
        bus_read(cnt_addr(CNT_REG_LO), lo);
        bus_read(cnt_addr(CNT_REG_HI), hi);
        cnt_got_q.push_back({hi, lo});
        cnt_exp_q.push_back(exp_cnt);
    endtask

    task automatic send_events(int n);
        repeat (n) begin
            event_in = 1'b1;
            wait_cycles(4);
            event_in = 1'b0;
            wait_cycles(4);
        end
        if (exp_en)
            exp_cnt = exp_cnt + 16'(n);              // Wraps like the counter.
    endtask

    task automatic reread_all();
        read_expect("gpio_out", gpio_addr(GPIO_REG_OUT), exp_out);
        read_expect("gpio_dir", gpio_addr(GPIO_REG_DIR), exp_dir);
        read_expect("gpio_in", gpio_addr(GPIO_REG_IN), gpio_in_ref(exp_out, exp_dir, tb_pins));
        read_expect("cnt_ctrl", cnt_addr(CNT_REG_CTRL), {7'b0, exp_en});
        read_count_pair();
    endtask

    // ********************
    // Compare
    // ********************
    task automatic check_data(string name, bus_data_t got, bus_data_t exp);
        if (got !== exp) begin
            data_err++;
            $display("ERROR %s: got 0x%02h, expected 0x%02h", name, got, exp);
        end
    endtask

    task automatic check_count(logic [15:0] got, logic [15:0] exp);
        if (got !== exp) begin
            count_err++;
            $display("ERROR count: got 0x%04h, expected 0x%04h", got, exp);
        end
    endtask

    initial begin : compare
        forever begin
            @(posedge bus_clk);
            while (got_q.size() > 0)
                check_data(name_q.pop_front(), got_q.pop_front(), exp_q.pop_front());
            while (cnt_got_q.size() > 0)
                check_count(cnt_got_q.pop_front(), cnt_exp_q.pop_front());
        end
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("Timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
        $display("Testbench failed");
        $finish;
    end

    // ********************
    // Stimulus
    // ********************
    initial begin : stimulus
        bus_data_t v;
        bus_addr_t a;
        int        n;
        int        total;
        seed     = 2091;
        add      = '0;
        rd_b     = 1'b1;
        wr_b     = 1'b1;
        wr_data  = '0;
        wr_drive = 1'b0;
        event_in = 1'b0;
        tb_pins  = '0;
        exp_out  = '0;
        exp_dir  = '0;
        exp_en   = 1'b0;
        exp_cnt  = '0;
        @(posedge rst_n);
        wait_cycles(2);

        if (bus_data !== 8'hzz) begin
            other_err++;
            $display("bus_data is driven while the bus is idle after reset");
        end
        read_expect("gpio_dir", gpio_addr(GPIO_REG_DIR), 8'h00);
        read_expect("gpio_out", gpio_addr(GPIO_REG_OUT), 8'h00);
        read_expect("cnt_ctrl", cnt_addr(CNT_REG_CTRL), 8'h00);
        read_expect("cnt_lo", cnt_addr(CNT_REG_LO), 8'h00);
        read_expect("cnt_hi", cnt_addr(CNT_REG_HI), 8'h00);

        for (int i = 0; i < N_GPIO; i++) begin
            exp_out = bus_data_t'($random(seed));
            bus_write(gpio_addr(GPIO_REG_OUT), exp_out);
            v = bus_data_t'($random(seed));
            bus_write(gpio_addr(GPIO_REG_DIR), v);
            exp_dir = v;
            read_expect("gpio_out", gpio_addr(GPIO_REG_OUT), exp_out);
            read_expect("gpio_dir", gpio_addr(GPIO_REG_DIR), exp_dir);
            post_data("io", io & exp_dir, exp_out & exp_dir);
        end

        for (int i = 0; i < N_MIX; i++) begin
            v = bus_data_t'($random(seed));
            bus_write(gpio_addr(GPIO_REG_DIR), v);
            exp_dir = v;
            tb_pins = bus_data_t'($random(seed));
            wait_cycles(3);                          // Input sync settles.
            read_expect("gpio_in", gpio_addr(GPIO_REG_IN),
                        gpio_in_ref(exp_out, exp_dir, tb_pins));
        end

        for (int r = 0; r < N_ROUNDS; r++) begin
            bus_write(cnt_addr(CNT_REG_CTRL), 8'h01);
            exp_en = 1'b1;
            n = 1 + ({$random(seed)} % MAX_EVENTS);
            send_events(n);
            bus_write(cnt_addr(CNT_REG_CTRL), 8'h00);
            exp_en = 1'b0;
            send_events(1 + ({$random(seed)} % MAX_OFF_EV));
            read_count_pair();
            read_expect("cnt_ctrl", cnt_addr(CNT_REG_CTRL), 8'h00);
        end

        bus_write(cnt_addr(CNT_REG_CTRL), 8'h03);    // Enable and clear.
        exp_en  = 1'b1;
        exp_cnt = '0;
        read_expect("cnt_ctrl", cnt_addr(CNT_REG_CTRL), 8'h01);
        read_count_pair();
        bus_write(cnt_addr(CNT_REG_CTRL), 8'h00);
        exp_en = 1'b0;

        for (int idx = 3; idx < 16; idx++) begin
            read_expect("gpio_unused", gpio_addr(reg_addr_t'(idx)), 8'h00);
            bus_write(gpio_addr(reg_addr_t'(idx)), bus_data_t'($random(seed)));
            read_expect("cnt_unused", cnt_addr(reg_addr_t'(idx)), 8'h00);
            bus_write(cnt_addr(reg_addr_t'(idx)), bus_data_t'($random(seed)));
        end

        for (int i = 0; i < N_UNMAP; i++) begin
            if (i == 0) begin
                a = 16'h3FFF;                        // Just below the map.
            end else if (i == 1) begin
                a = 16'h4020;                        // Just above the map.
            end else begin
                do a = bus_addr_t'($random(seed));
                while (a >= 16'h4000 && a <= 16'h401F);
            end
            read_expect("unmapped", a, 8'h00);
            bus_write(a, bus_data_t'($random(seed)));
        end
        reread_all();

        // Index 2 is dir in one window and ctrl in the other.
        v = bus_data_t'($random(seed)) | 8'h81;
        bus_write(gpio_addr(GPIO_REG_DIR), v);
        exp_dir = v;
        read_expect("cnt_ctrl", cnt_addr(CNT_REG_CTRL), 8'h00);
        read_expect("gpio_dir", gpio_addr(GPIO_REG_DIR), exp_dir);
        bus_write(cnt_addr(CNT_REG_CTRL), 8'h01);
        exp_en = 1'b1;
        read_expect("gpio_dir", gpio_addr(GPIO_REG_DIR), exp_dir);
        read_expect("cnt_ctrl", cnt_addr(CNT_REG_CTRL), 8'h01);
        bus_write(cnt_addr(CNT_REG_CTRL), 8'h00);
        exp_en = 1'b0;

        wait_cycles(2);                              // Let the compare queues drain.
        total = data_err + count_err + other_err
                + i_bus_top.i_bus_ctrl.i_bus_top_chk.fail_count;
        $display("Errors: data %0d, count %0d, other %0d, assertion %0d, total %0d",
                 data_err, count_err, other_err,
                 i_bus_top.i_bus_ctrl.i_bus_top_chk.fail_count, total);
        if (total == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* flist.f */
common/bus_pkg.sv
common/reg_if.sv
bus_ctrl/bus_ctrl.sv
gpio/gpio_port.sv
event_counter/event_counter.sv
src/bus_top.sv
tests/clk_rst_gen.sv
tests/bus_top_chk.sv
tests/tb_bus_top.sv
